// ==== design/gpio_port.sv ====
/*
 * GPIO window with an 8-bit output latch and an 8-bit input.
 * The latch is written and read back at gpio_out_reg; the input is
 * brought into the clock domain by two flops and read at gpio_in_reg.
 */
`timescale 1ns/1ps
`default_nettype none

module gpio_port
    import periph_pkg::*;
#(
    parameter int          addr_width = 16,
    parameter int unsigned base_addr  = 'hFF00
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] addr,
    input  logic                  read_en,
    input  logic                  write_en,
    input  logic [data_width-1:0] write_data,
    input  logic [data_width-1:0] gpio_in,
    output logic [data_width-1:0] gpio_out,
    output logic [data_width-1:0] read_data
);

    localparam logic [addr_width-1:0] win_base = addr_width'(base_addr + gpio_offset);

    logic [addr_width-1:0] rel_addr;
    logic                  sel;
    logic                  offset;
    logic                  wr_out;
    logic [data_width-1:0] sync_meta;
    logic [data_width-1:0] sync_in;

    assign rel_addr = addr - win_base;
    assign sel      = rel_addr < addr_width'(gpio_span);
    assign offset   = rel_addr[0];
    assign wr_out   = write_en && sel && offset == 1'(gpio_out_reg);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_out <= '0;
        end else if (wr_out) begin
            gpio_out <= write_data;
        end
    end

    // Two-stage synchronizer for the asynchronous pins.
    always_ff @(posedge clk) begin
        sync_meta <= gpio_in;
        sync_in   <= sync_meta;
    end

    always_comb begin
        read_data = '0;
        if (read_en && sel) begin
            if (offset == 1'(gpio_out_reg)) begin
                read_data = gpio_out;
            end else begin
                read_data = sync_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/hardware_info.sv ====
/*
 * Hardware-information window.
 * Four read-only registers report the clock in MHz, the word-size code
 * and which peripherals are built. Give it the same parameters as the
 * top level so the reported values match the built hardware.
 */
`timescale 1ns/1ps
`default_nettype none

module hardware_info
    import periph_pkg::*;
#(
    parameter int          addr_width   = 16,
    parameter int unsigned base_addr    = 'hFF00,
    parameter int          wordsize     = 16,
    parameter int          clk_freq     = 1000000,
    parameter int          enable_gpio  = 1,
    parameter int          enable_timer = 1
) (
    input  logic                  read_en,
    input  logic [addr_width-1:0] addr,
    output logic [data_width-1:0] read_data
);

    localparam logic [addr_width-1:0] win_base = addr_width'(base_addr + hwi_offset);
    localparam int clk_mhz = clk_freq / 1000000;

    logic [addr_width-1:0] rel_addr;
    logic                  using_hwi;
    logic [1:0]            offset;
    logic [data_width-1:0] clk_lsb;
    logic [data_width-1:0] clk_msb;
    logic [data_width-1:0] info1;
    logic [data_width-1:0] info2;
    logic [data_width-1:0] dout_clk_lsb;
    logic [data_width-1:0] dout_clk_msb;
    logic [data_width-1:0] dout_info1;
    logic [data_width-1:0] dout_info2;

    // Subtracting first keeps the window test correct near the top of memory.
    assign rel_addr  = addr - win_base;
    assign using_hwi = read_en && rel_addr < addr_width'(hwi_span);
    assign offset    = rel_addr[1:0];

    assign clk_lsb = 8'(clk_mhz);
    assign clk_msb = 8'(clk_mhz >> 8);

    // uart, timer2 and exti are not part of this build.
    assign info1 = {1'b0, 1'b0, enable_timer != 0, enable_gpio != 0, 1'b0,
                    wordsize_code(wordsize)};
    assign info2 = '0;

    ro_register #(.addr_size(2), .reg_addr(hwi_clk_lsb)) u_clk_lsb (
        .enable   (using_hwi),
        .addr     (offset),
        .data     (clk_lsb),
        .data_out (dout_clk_lsb)
    );

    ro_register #(.addr_size(2), .reg_addr(hwi_clk_msb)) u_clk_msb (
        .enable   (using_hwi),
        .addr     (offset),
        .data     (clk_msb),
        .data_out (dout_clk_msb)
    );

    ro_register #(.addr_size(2), .reg_addr(hwi_info1)) u_info1 (
        .enable   (using_hwi),
        .addr     (offset),
        .data     (info1),
        .data_out (dout_info1)
    );

    ro_register #(.addr_size(2), .reg_addr(hwi_info2)) u_info2 (
        .enable   (using_hwi),
        .addr     (offset),
        .data     (info2),
        .data_out (dout_info2)
    );

    assign read_data = dout_clk_lsb | dout_clk_msb | dout_info1 | dout_info2;

endmodule

`default_nettype wire

// ==== design/interval_timer.sv ====
/*
 * Interval timer window.
 * A down-counter steps once every prescale+1 cycles while run is set,
 * reloads when it is stepped at zero and raises the interrupt flag.
 * Software clears the flag by writing 1 to its control bit.
 */
`timescale 1ns/1ps
`default_nettype none

module interval_timer
    import periph_pkg::*;
#(
    parameter int          addr_width = 16,
    parameter int unsigned base_addr  = 'hFF00
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] addr,
    input  logic                  read_en,
    input  logic                  write_en,
    input  logic [data_width-1:0] write_data,
    output logic [data_width-1:0] read_data,
    output logic                  irq
);

    localparam logic [addr_width-1:0] win_base = addr_width'(base_addr + timer_offset);

    logic [addr_width-1:0] rel_addr;
    logic                  sel;
    logic [1:0]            offset;
    logic                  wr_reload;
    logic                  wr_prescale;
    logic                  wr_ctrl;
    logic                  start;
    logic                  tick;
    logic [data_width-1:0] reload;
    logic [data_width-1:0] prescale;
    logic [data_width-1:0] presc_cnt;
    logic [data_width-1:0] count;
    logic [data_width-1:0] ctrl_val;
    logic                  run;
    logic                  flag;

    assign rel_addr    = addr - win_base;
    assign sel         = rel_addr < addr_width'(timer_span);
    assign offset      = rel_addr[1:0];
    assign wr_reload   = write_en && sel && offset == 2'(timer_reload_reg);
    assign wr_prescale = write_en && sel && offset == 2'(timer_prescale_reg);
    assign wr_ctrl     = write_en && sel && offset == 2'(timer_ctrl_reg);

    // Count loads only when run goes from 0 to 1.
    assign start = wr_ctrl && write_data[ctrl_run_bit] && !run;
    assign tick  = run && presc_cnt == prescale;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reload   <= '0;
            prescale <= '0;
            run      <= 1'b0;
        end else begin
            if (wr_reload) reload <= write_data;
            if (wr_prescale) prescale <= write_data;
            if (wr_ctrl) run <= write_data[ctrl_run_bit];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            presc_cnt <= '0;
            count     <= '0;
        end else if (start) begin
            presc_cnt <= '0;
            count     <= reload;
        end else if (tick) begin
            presc_cnt <= '0;
            count     <= (count == '0) ? reload : count - 1'b1;
        end else if (run) begin
            presc_cnt <= presc_cnt + 1'b1;
        end
    end

    // A new event wins over a clear in the same cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag <= 1'b0;
        end else if (tick && count == '0) begin
            flag <= 1'b1;
        end else if (wr_ctrl && write_data[ctrl_flag_bit]) begin
            flag <= 1'b0;
        end
    end

    assign irq = flag;

    always_comb begin
        ctrl_val                = '0;
        ctrl_val[ctrl_run_bit]  = run;
        ctrl_val[ctrl_flag_bit] = flag;
    end

    always_comb begin
        read_data = '0;
        if (read_en && sel) begin
            case (offset)
                2'(timer_reload_reg):   read_data = reload;
                2'(timer_prescale_reg): read_data = prescale;
                2'(timer_ctrl_reg):     read_data = ctrl_val;
                default:                read_data = count;
            endcase
        end
    end

    // A stopped timer holds its count apart from the load on start.
    assert property (@(posedge clk) disable iff (!arst_n)
        (!run && !start) |=> $stable(count));

    // No interrupt can be raised by a stopped timer.
    assert property (@(posedge clk) disable iff (!arst_n)
        !run |=> !$rose(flag));

endmodule

`default_nettype wire

// ==== design/periph_bus.sv ====
/*
 * Top level of the peripheral block.
 * Places the hardware-information, GPIO and timer windows on the shared
 * register bus. Unselected windows return zero, so read data is an OR.
 * Peripherals that are not enabled are left out and read as zero.
 */
`timescale 1ns/1ps
`default_nettype none

module periph_bus
    import periph_pkg::*;
#(
    parameter int          addr_width   = 16,
    parameter int unsigned base_addr    = 'hFF00,
    parameter int          wordsize     = 16,
    parameter int          clk_freq     = 1000000,
    parameter int          enable_gpio  = 1,
    parameter int          enable_timer = 1
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] addr,
    input  logic                  read_en,
    input  logic                  write_en,
    input  logic [data_width-1:0] write_data,
    input  logic [data_width-1:0] gpio_in,
    output logic [data_width-1:0] gpio_out,
    output logic [data_width-1:0] read_data,
    output logic                  timer_irq
);

    logic [data_width-1:0] hwi_rd;
    logic [data_width-1:0] gpio_rd;
    logic [data_width-1:0] timer_rd;

    hardware_info #(
        .addr_width   (addr_width),
        .base_addr    (base_addr),
        .wordsize     (wordsize),
        .clk_freq     (clk_freq),
        .enable_gpio  (enable_gpio),
        .enable_timer (enable_timer)
    ) u_hwi (
        .read_en   (read_en),
        .addr      (addr),
        .read_data (hwi_rd)
    );

    if (enable_gpio != 0) begin : g_gpio
        gpio_port #(
            .addr_width (addr_width),
            .base_addr  (base_addr)
        ) u_gpio (
            .clk        (clk),
            .arst_n     (arst_n),
            .addr       (addr),
            .read_en    (read_en),
            .write_en   (write_en),
            .write_data (write_data),
            .gpio_in    (gpio_in),
            .gpio_out   (gpio_out),
            .read_data  (gpio_rd)
        );
    end else begin : g_no_gpio
        assign gpio_out = '0;
        assign gpio_rd  = '0;
    end

    if (enable_timer != 0) begin : g_timer
        interval_timer #(
            .addr_width (addr_width),
            .base_addr  (base_addr)
        ) u_timer (
            .clk        (clk),
            .arst_n     (arst_n),
            .addr       (addr),
            .read_en    (read_en),
            .write_en   (write_en),
            .write_data (write_data),
            .read_data  (timer_rd),
            .irq        (timer_irq)
        );
    end else begin : g_no_timer
        assign timer_irq = 1'b0;
        assign timer_rd  = '0;
    end

    assign read_data = hwi_rd | gpio_rd | timer_rd;

    // The bus master issues at most one access per cycle.
    assert property (@(posedge clk) disable iff (!arst_n)
        !(read_en && write_en));

endmodule

`default_nettype wire

// ==== design/periph_pkg.sv ====
/*
 * Shared definitions for the memory-mapped peripheral block.
 * Window placement, register offsets and the hardware-information
 * word-size encoding. Modules pull these in by a wildcard import.
 */
`default_nettype none

package periph_pkg;

    localparam int data_width = 8;

    // Window starts relative to base_addr, and their sizes.
    localparam int hwi_offset   = 0;
    localparam int gpio_offset  = 4;
    localparam int timer_offset = 8;
    localparam int hwi_span     = 4;
    localparam int gpio_span    = 2;
    localparam int timer_span   = 4;

    // Hardware-information registers.
    localparam int hwi_clk_lsb = 0;
    localparam int hwi_clk_msb = 1;
    localparam int hwi_info1   = 2;
    localparam int hwi_info2   = 3;

    // GPIO registers.
    localparam int gpio_out_reg = 0;
    localparam int gpio_in_reg  = 1;

    // Timer registers and control bits.
    localparam int timer_reload_reg   = 0;
    localparam int timer_prescale_reg = 1;
    localparam int timer_ctrl_reg     = 2;
    localparam int timer_count_reg    = 3;
    localparam int ctrl_run_bit       = 0;
    localparam int ctrl_flag_bit      = 1;

    function automatic logic [2:0] wordsize_code(input int size);
        case (size)
            8:       return 3'd1;
            16:      return 3'd2;
            32:      return 3'd3;
            64:      return 3'd4;
            128:     return 3'd5;
            default: return 3'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== design/ro_register.sv ====
/*
 * Single read-only register on the peripheral bus.
 * Puts its data on data_out when enabled and addressed at reg_addr,
 * and zero otherwise, so several of them can be ORed together.
 */
`timescale 1ns/1ps
`default_nettype none

module ro_register
    import periph_pkg::*;
#(
    parameter int addr_size = 2,
    parameter int reg_addr  = 0
) (
    input  logic                  enable,
    input  logic [addr_size-1:0]  addr,
    input  logic [data_width-1:0] data,
    output logic [data_width-1:0] data_out
);

    assign data_out = (enable && addr == addr_size'(reg_addr)) ? data : '0;

    // An idle register must not disturb the OR of its neighbours.
    always_comb begin
        assert (enable || data_out == '0);
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Builds the peripheral bus testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f --top-module periph_bus_tb -o periph_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/periph_sim); then
    printf '%s\n' "$sim_out"
    echo "Simulation exited with an error"
    exit 1
fi
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'RESULT: PASS'; then
    exit 0
fi
exit 1

// ==== sim.f ====
design/periph_pkg.sv
design/ro_register.sv
design/hardware_info.sv
design/gpio_port.sv
design/interval_timer.sv
design/periph_bus.sv
verif/tb_clock.sv
verif/periph_bus_tb.sv

// ==== verif/periph_bus_tb.sv ====
/*
 * Table-driven testbench for the peripheral bus top level.
 * Each table entry is a read, write, poll or gpio_in change, applied
 * in order after reset; one line is printed per entry, then the counts.
 */
`timescale 1ns/1ps
`default_nettype none

module periph_bus_tb
    import periph_pkg::*;
();

    // Own copy of the DUT defaults for deriving expected values.
    localparam int addr_width   = 16;
    localparam int base_addr    = 'hFF00;
    localparam int wordsize     = 16;
    localparam int clk_freq     = 1000000;
    localparam int enable_gpio  = 1;
    localparam int enable_timer = 1;

    localparam int op_read = 0;
    localparam int op_write = 1;
    localparam int op_poll = 2;
    localparam int op_set_in = 3;
    // Expected-value markers for no check with the value kept, and for equal to the kept value.
    localparam int exp_any = -1;
    localparam int exp_kept = -2;

    localparam int gpio_out_off = gpio_offset + gpio_out_reg;
    localparam int gpio_in_off = gpio_offset + gpio_in_reg;
    localparam int reload_off = timer_offset + timer_reload_reg;
    localparam int prescale_off = timer_offset + timer_prescale_reg;
    localparam int ctrl_off = timer_offset + timer_ctrl_reg;
    localparam int count_off = timer_offset + timer_count_reg;
    localparam int run_val = 1 << ctrl_run_bit;
    localparam int flag_val = 1 << ctrl_flag_bit;
    localparam int tb_reload = 5;

    logic                  clk;
    logic                  arst_n;
    logic [addr_width-1:0] addr;
    logic                  read_en;
    logic                  write_en;
    logic [data_width-1:0] write_data;
    logic [data_width-1:0] gpio_in;
    logic [data_width-1:0] gpio_out;
    logic [data_width-1:0] read_data;
    logic                  timer_irq;

    int          t_op[$];
    int          t_off[$];
    int          t_data[$];
    int          t_exp[$];
    string       t_name[$];
    int          pass_count;
    int          fail_count;
    int          kept;
    logic [31:0] rng;

    tb_clock #(.period(20)) u_clock (.clk(clk));

    periph_bus uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .addr       (addr),
        .read_en    (read_en),
        .write_en   (write_en),
        .write_data (write_data),
        .gpio_in    (gpio_in),
        .gpio_out   (gpio_out),
        .read_data  (read_data),
        .timer_irq  (timer_irq)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Word size 2**b maps to code b-2 for b from 3 to 7.
    function automatic int wordsize_to_code(input int size);
        int code;
        code = 0;
        for (int b = 3; b <= 7; b++) begin
            if (size == (1 << b)) code = b - 2;
        end
        return code;
    endfunction

    function automatic bit check_equal(input string what, input int got, input int want);
        if (got != want) begin
            $display("mismatch at %0t ns: %s got 0x%02h, expected 0x%02h", $time, what, got,
                     want);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // Pin that a write to this offset is expected to drive.
    function automatic int pin_value(input int off);
        if (off == gpio_out_off) return int'(gpio_out);
        return int'(timer_irq);
    endfunction

    task automatic add_entry(input int op, input int off, input int data, input int exp,
                             input string name);
        t_op.push_back(op);
        t_off.push_back(off);
        t_data.push_back(data);
        t_exp.push_back(exp);
        t_name.push_back(name);
    endtask

    // The data field holds the read_en level for reads and the read limit for polls.
    task automatic build_table();
        int mhz;
        int info1;
        int val;
        mhz = clk_freq / 1000000;
        info1 = wordsize_to_code(wordsize) | (enable_gpio << 4) | (enable_timer << 5);
        add_entry(op_read, hwi_offset + hwi_clk_lsb, 1, mhz % 256, "hwi clock lsb");
        add_entry(op_read, hwi_offset + hwi_clk_msb, 1, (mhz / 256) % 256, "hwi clock msb");
        add_entry(op_read, hwi_offset + hwi_info1, 1, info1, "hwi info1");
        add_entry(op_read, hwi_offset + hwi_info2, 1, 0, "hwi info2");
        add_entry(op_read, 6, 1, 0, "gap after gpio");
        add_entry(op_read, 12, 1, 0, "past timer window");
        add_entry(op_read, -1, 1, 0, "below base");
        add_entry(op_read, 'hFE, 1, 0, "top of memory");
        add_entry(op_read, hwi_offset + hwi_info1, 0, 0, "info1 with read_en low");
        add_entry(op_read, gpio_out_off, 1, 0, "gpio_out after reset");
        add_entry(op_read, reload_off, 1, 0, "reload after reset");
        add_entry(op_read, prescale_off, 1, 0, "prescale after reset");
        add_entry(op_read, ctrl_off, 1, 0, "ctrl after reset");
        add_entry(op_read, count_off, 1, 0, "count after reset");
        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            val = int'(rng[7:0]);
            add_entry(op_write, gpio_out_off, val, val, "gpio_out pins");
            add_entry(op_read, gpio_out_off, 1, val, "gpio_out readback");
        end
        for (int i = 0; i < 2; i++) begin
            rng = xorshift32(rng);
            val = int'(rng[7:0]);
            add_entry(op_set_in, 0, val, 0, "set gpio_in");
            add_entry(op_poll, gpio_in_off, 4, val, "gpio_in synchronized");
        end
        add_entry(op_write, reload_off, tb_reload, exp_any, "timer reload write");
        add_entry(op_write, prescale_off, 0, exp_any, "timer prescale write");
        add_entry(op_read, reload_off, 1, tb_reload, "timer reload readback");
        add_entry(op_write, ctrl_off, run_val, 0, "timer start, irq low");
        add_entry(op_poll, ctrl_off, 40, run_val | flag_val, "timer flag and irq rise");
        add_entry(op_write, ctrl_off, run_val | flag_val, 0, "flag clear drops irq");
        add_entry(op_read, ctrl_off, 1, run_val, "flag clear readback");
        // The stop edge may still be a reload step, so the flag is cleared after it.
        add_entry(op_write, ctrl_off, 0, exp_any, "timer stop");
        add_entry(op_write, ctrl_off, flag_val, 0, "flag clear after stop");
        add_entry(op_read, count_off, 1, exp_any, "count after stop");
        for (int i = 0; i < 3; i++) begin
            add_entry(op_read, ctrl_off, 1, 0, "flag stays clear");
        end
        add_entry(op_read, count_off, 1, exp_kept, "count holds while stopped");
    endtask

    // Read data is sampled in the middle of the low phase after it has settled.
    task automatic bus_read(input int off, input bit ren, output int val);
        @(negedge clk);
        addr = addr_width'(base_addr + off);
        write_en = 1'b0;
        read_en = ren;
        #5;
        val = int'(read_data);
    endtask

    task automatic bus_write(input int off, input int data);
        @(negedge clk);
        addr = addr_width'(base_addr + off);
        read_en = 1'b0;
        write_en = 1'b1;
        write_data = data_width'(data);
        @(negedge clk);
        write_en = 1'b0;
        #5;
    endtask

    task automatic poll_reg(input int idx, output bit ok);
        int val;
        int cnt;
        int tries;
        bit done;
        ok = 1'b1;
        done = 1'b0;
        tries = 0;
        while (!done && tries < t_data[idx]) begin
            bus_read(t_off[idx], 1'b1, val);
            tries++;
            if (val == t_exp[idx]) begin
                done = 1'b1;
            end else if (t_off[idx] == ctrl_off) begin
                // The running count must never exceed the reload value.
                bus_read(count_off, 1'b1, cnt);
                if (cnt > tb_reload) begin
                    $display("mismatch at %0t ns: count 0x%02h above reload", $time, cnt);
                    ok = 1'b0;
                end
            end
        end
        if (!done) begin
            $display("%s: value never reached after %0d reads, poll timed out", t_name[idx],
                     tries);
            ok = 1'b0;
        end else if (t_off[idx] == ctrl_off) begin
            ok &= check_equal("timer_irq", int'(timer_irq), (t_exp[idx] >> ctrl_flag_bit) & 1);
        end
    endtask

    task automatic apply_entry(input int idx);
        int val;
        bit ok;
        ok = 1'b1;
        case (t_op[idx])
            op_read: begin
                bus_read(t_off[idx], t_data[idx] != 0, val);
                if (t_exp[idx] == exp_any) kept = val;
                else if (t_exp[idx] == exp_kept) ok = check_equal(t_name[idx], val, kept);
                else ok = check_equal(t_name[idx], val, t_exp[idx]);
            end
            op_write: begin
                bus_write(t_off[idx], t_data[idx]);
                if (t_exp[idx] != exp_any) begin
                    ok = check_equal(t_name[idx], pin_value(t_off[idx]), t_exp[idx]);
                end
            end
            op_poll: poll_reg(idx, ok);
            default: begin
                @(negedge clk);
                read_en = 1'b0;
                gpio_in = data_width'(t_data[idx]);
            end
        endcase
        if (ok) pass_count++;
        else fail_count++;
        $display("test %0d %s: %s", idx, t_name[idx], ok ? "passed" : "failed");
    endtask

    initial begin
        arst_n = 1'b0;
        addr = '0;
        read_en = 1'b0;
        write_en = 1'b0;
        write_data = '0;
        gpio_in = '0;
        pass_count = 0;
        fail_count = 0;
        kept = 0;
        rng = 32'd96;
        build_table();
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        #5;
        if (gpio_out != '0 || timer_irq != 1'b0) begin
            $display("mismatch at %0t ns: output pins not zero after reset", $time);
            fail_count++;
            $display("test reset pins: failed");
        end else begin
            pass_count++;
            $display("test reset pins: passed");
        end
        for (int i = 0; i < t_op.size(); i++) begin
            apply_entry(i);
        end
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
/*
 * Free-running clock for the testbench, low at time zero.
 * The period is set by parameter, in nanoseconds.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(period / 2);
        clk = ~clk;
    end

endmodule

`default_nettype wire
